// ==== Bender.yml ====
package:
  name: tile_feat

dependencies: {}

sources:
  - rtl/tile_feat_pkg.sv
  - rtl/pix_linebuf.sv
  - rtl/tile_stats_accum.sv
  - rtl/tile_out_fifo.sv
  - rtl/tile_feat_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tile_feat_tb.sv

// ==== dv/tile_feat_model.svh ====
// reference model for the tile feature extractor, included inside the testbench module
`ifndef TILE_FEAT_MODEL_SVH
`define TILE_FEAT_MODEL_SVH

// one expected output record, mean kept as its own field
typedef struct packed {
  logic [TX_W-1:0]       tile_x;
  logic [TY_W-1:0]       tile_y;
  logic [FRAME_ID_W-1:0] frame_id;
  logic [SUM_W-1:0]      sum;
  logic [PIX_W-1:0]      min_v;
  logic [PIX_W-1:0]      max_v;
  logic [PIX_W-1:0]      mean;
  logic [EDGE_W-1:0]     edge_sum;
} exp_rec_t;

// frame under test, row major
logic [PIX_W-1:0] frame_pix [ACTIVE_H][ACTIVE_W];
exp_rec_t         exp_q [$];

function automatic int abs_delta(input int a, input int b);
  return (a > b) ? (a - b) : (b - a);
endfunction

// kinds: 0 random, 1 flat, 2 vertical stripes two pixels wide
task automatic fill_frame(input int kind);
  for (int y = 0; y < ACTIVE_H; y++) begin
    for (int x = 0; x < ACTIVE_W; x++) begin
      case (kind)
        0:       frame_pix[y][x] = PIX_W'($urandom_range(0, 255));
        1:       frame_pix[y][x] = 8'h5a;
        default: frame_pix[y][x] = x[1] ? 8'he0 : 8'h18;
      endcase
    end
  end
endtask

// records of every tile lying inside the first full_rows lines, raster tile order
task automatic predict_tiles(input logic [FRAME_ID_W-1:0] fid, input int full_rows);
  int       sum;
  int       mn;
  int       mx;
  int       eg;
  int       px;
  int       gx;
  int       gy;
  exp_rec_t rec;
  for (int ty = 0; ty < TILES_Y; ty++) begin
    if ((ty + 1) * TILE_DIM <= full_rows) begin
      for (int tx = 0; tx < TILES_X; tx++) begin
        sum = 0;
        mn  = 255;
        mx  = 0;
        eg  = 0;
        for (int yy = 0; yy < TILE_DIM; yy++) begin
          for (int xx = 0; xx < TILE_DIM; xx++) begin
            gx  = tx * TILE_DIM + xx;
            gy  = ty * TILE_DIM + yy;
            px  = frame_pix[gy][gx];
            sum = sum + px;
            if (px < mn) mn = px;
            if (px > mx) mx = px;
            // gradients only toward neighbours inside the same tile
            if (xx != 0) eg = eg + abs_delta(px, frame_pix[gy][gx-1]);
            if (yy != 0) eg = eg + abs_delta(px, frame_pix[gy-1][gx]);
          end
        end
        rec.tile_x   = TX_W'(tx);
        rec.tile_y   = TY_W'(ty);
        rec.frame_id = fid;
        rec.sum      = SUM_W'(sum);
        rec.min_v    = PIX_W'(mn);
        rec.max_v    = PIX_W'(mx);
        // mean is the plain sum over the 16 tile pixels
        rec.mean     = PIX_W'(sum / (TILE_DIM * TILE_DIM));
        rec.edge_sum = EDGE_W'(eg);
        exp_q.push_back(rec);
      end
    end
  end
endtask

`endif

// ==== dv/tile_feat_tb.sv ====
// testbench for the tile feature extractor checking random, flat, striped and aborted frames
module tile_feat_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import tile_feat_pkg::*;

  `include "tile_feat_model.svh"

  localparam int PIX_TIMEOUT   = 200;
  localparam int DRAIN_TIMEOUT = 3000;

  logic                  clk;
  logic                  rst_i;
  logic                  pix_valid_i;
  logic                  pix_ready_o;
  logic                  sof_i;
  logic [PIX_W-1:0]      pix_i;
  logic                  out_valid_o;
  logic                  out_ready_i;
  logic [TX_W-1:0]       tile_x_o;
  logic [TY_W-1:0]       tile_y_o;
  logic [FRAME_ID_W-1:0] frame_id_o;
  logic [SUM_W-1:0]      sum_o;
  logic [PIX_W-1:0]      min_o;
  logic [PIX_W-1:0]      max_o;
  logic [PIX_W-1:0]      mean_o;
  logic [EDGE_W-1:0]     edge_o;
  logic                  err_sof_midframe_o;

  int                    mismatch_cnt;
  int                    proto_cnt;
  int                    timeout_cnt;
  int                    err_pulses;
  bit                    ready_random;
  logic [FRAME_ID_W-1:0] next_fid;
  exp_rec_t              head;

  tile_feat_top UUT (
    .clk(clk), .rst_i(rst_i), .pix_valid_i(pix_valid_i), .pix_ready_o(pix_ready_o),
    .sof_i(sof_i), .pix_i(pix_i), .out_valid_o(out_valid_o), .out_ready_i(out_ready_i),
    .tile_x_o(tile_x_o), .tile_y_o(tile_y_o), .frame_id_o(frame_id_o), .sum_o(sum_o),
    .min_o(min_o), .max_o(max_o), .mean_o(mean_o), .edge_o(edge_o),
    .err_sof_midframe_o(err_sof_midframe_o)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // sink ready is about 30 percent high under back-pressure
  always @(posedge clk) begin
    #1;
    out_ready_i = ready_random ? ($urandom_range(0, 9) < 3) : 1'b1;
  end

  task automatic compare_field(input string name, input int got, input int exp);
    assert (got == exp) else begin
      mismatch_cnt++;
      $display("MISMATCH %s got %h expected %h", name, got, exp);
    end
  endtask

  // ------------------------------------------------------------------
  // output monitor sampled mid-cycle where everything is settled
  // ------------------------------------------------------------------
  always @(negedge clk) begin
    if (!rst_i) begin
      if (err_sof_midframe_o) err_pulses++;
      if (out_valid_o && out_ready_i) begin
        if (exp_q.size() == 0) begin
          proto_cnt++;
          $display("unexpected record for tile (%0d,%0d), none was expected", tile_x_o, tile_y_o);
        end else begin
          head = exp_q.pop_front();
          compare_field("tile_x_o", tile_x_o, head.tile_x);
          compare_field("tile_y_o", tile_y_o, head.tile_y);
          compare_field("frame_id_o", frame_id_o, head.frame_id);
          compare_field("sum_o", sum_o, head.sum);
          compare_field("min_o", min_o, head.min_v);
          compare_field("max_o", max_o, head.max_v);
          compare_field("mean_o", mean_o, head.mean);
          compare_field("edge_o", edge_o, head.edge_sum);
        end
      end
    end
  end

  // ------------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------------
  // holds valid and data until a ready edge with an optional idle gap in front
  task automatic send_pixel(input logic [PIX_W-1:0] p, input logic sof);
    int   waited;
    logic taken;
    waited = 0;
    taken  = 1'b0;
    if (ready_random) begin
      pix_valid_i = 1'b0;
      repeat ($urandom_range(0, 2)) begin
        @(posedge clk);
        #1;
      end
    end
    pix_valid_i = 1'b1;
    sof_i       = sof;
    pix_i       = p;
    while (!taken && waited < PIX_TIMEOUT) begin
      @(negedge clk);
      taken = pix_ready_o;
      @(posedge clk);
      #1;
      waited++;
    end
    pix_valid_i = 1'b0;
    sof_i       = 1'b0;
    if (!taken) begin
      timeout_cnt++;
      $display("timeout, pixel not accepted within %0d cycles", PIX_TIMEOUT);
    end
  endtask

  // first n_pix pixels of the stored frame in raster order with sof on the first
  task automatic send_frame(input int n_pix);
    for (int i = 0; i < n_pix; i++) begin
      send_pixel(frame_pix[i / ACTIVE_W][i % ACTIVE_W], i == 0);
    end
  endtask

  // pixels without sof are dropped outside a frame
  task automatic send_junk(input int n);
    repeat (n) send_pixel(PIX_W'($urandom_range(0, 255)), 1'b0);
  endtask

  task automatic run_frame(input int kind);
    fill_frame(kind);
    predict_tiles(next_fid, ACTIVE_H);
    send_frame(ACTIVE_W * ACTIVE_H);
    next_fid++;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (exp_q.size() != 0) begin
      timeout_cnt++;
      $display("timeout, %0d expected records never left the DUT", exp_q.size());
    end
  endtask

  initial begin
    void'($urandom(32'h6259_ca8f));
    rst_i        = 1'b1;
    pix_valid_i  = 1'b0;
    sof_i        = 1'b0;
    pix_i        = '0;
    out_ready_i  = 1'b1;
    ready_random = 1'b0;
    next_fid     = '0;
    mismatch_cnt = 0;
    proto_cnt    = 0;
    timeout_cnt  = 0;
    err_pulses   = 0;
    repeat (2) @(posedge clk);
    #1;
    rst_i = 1'b0;

    // junk ahead of the first sof spans more than one tile row
    send_junk(TILE_DIM * ACTIVE_W + 4);
    run_frame(0);
    run_frame(0);
    run_frame(1);
    run_frame(2);
    wait_drain();

    // back-pressure and input gaps
    ready_random = 1'b1;
    repeat (3) begin
      run_frame(0);
      send_junk(5);
    end
    wait_drain();

    // no frame has been cut short up to here
    assert (err_pulses == 0) else begin
      proto_cnt++;
      $display("err_sof_midframe_o pulsed although no frame was cut short");
    end

    // abort a little past the first tile row which is still reported
    fill_frame(0);
    predict_tiles(next_fid, TILE_DIM + 1);
    send_frame((TILE_DIM + 1) * ACTIVE_W + 3);
    next_fid++;
    run_frame(0);
    assert (err_pulses == 1) else begin
      proto_cnt++;
      $display("sof inside a frame did not pulse err_sof_midframe_o exactly once");
    end
    wait_drain();
    ready_random = 1'b0;
    repeat (5) @(posedge clk);

    $display("errors: %0d mismatches, %0d protocol, %0d timeouts",
             mismatch_cnt, proto_cnt, timeout_cnt);
    if (mismatch_cnt + proto_cnt + timeout_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== rtl/pix_linebuf.sv ====
// raster coordinate counter with sof framing and a one-line luma buffer feeding neighbour pixels
module pix_linebuf (
  input  logic                                 clk,
  input  logic                                 rst_i,
  input  logic                                 pix_valid_i,
  output logic                                 pix_ready_o,
  input  logic                                 sof_i,
  input  logic [tile_feat_pkg::PIX_W-1:0]      pix_i,
  output logic                                 nb_valid_o,
  input  logic                                 nb_ready_i,
  output logic [tile_feat_pkg::PIX_W-1:0]      cur_pix_o,
  output logic [tile_feat_pkg::PIX_W-1:0]      left_pix_o,
  output logic [tile_feat_pkg::PIX_W-1:0]      up_pix_o,
  output logic [tile_feat_pkg::TILE_SHIFT-1:0] x_mod_o,
  output logic [tile_feat_pkg::TILE_SHIFT-1:0] y_mod_o,
  output logic [tile_feat_pkg::TX_W-1:0]       tile_x_o,
  output logic [tile_feat_pkg::TY_W-1:0]       tile_y_o,
  output logic [tile_feat_pkg::FRAME_ID_W-1:0] frame_id_o,
  output logic                                 err_sof_midframe_o
);
  import tile_feat_pkg::*;

  frame_state_t          state_q;
  logic [X_W-1:0]        x_q;
  logic [Y_W-1:0]        y_q;
  logic [FRAME_ID_W-1:0] frame_id_q;
  logic [PIX_W-1:0]      left_q;

  // one line of luma, indexed by x
  logic [PIX_W-1:0]      line_mem [ACTIVE_W];

  logic                  pix_fire;
  logic                  pix_take;
  logic [X_W-1:0]        cur_x;
  logic [Y_W-1:0]        cur_y;
  logic [FRAME_ID_W-1:0] cur_frame_id;
  logic                  last_x;
  logic                  last_y;

  // ------------------------------------------------------------------
  // accept and position of the incoming pixel
  // ------------------------------------------------------------------
  // single output stage, refill while it drains
  assign pix_ready_o = !nb_valid_o || nb_ready_i;
  assign pix_fire    = pix_valid_i && pix_ready_o;

  // pixels before the first sof are dropped
  assign pix_take = pix_fire && (sof_i || (state_q == FR_ACTIVE));

  // sof forces the origin
  assign cur_x        = sof_i ? '0 : x_q;
  assign cur_y        = sof_i ? '0 : y_q;
  assign cur_frame_id = sof_i ? frame_id_q + 1'b1 : frame_id_q;

  assign last_x = (cur_x == X_W'(ACTIVE_W - 1));
  assign last_y = (cur_y == Y_W'(ACTIVE_H - 1));

  // ------------------------------------------------------------------
  // framing control
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q            <= FR_WAIT_SOF;
      x_q                <= '0;
      y_q                <= '0;
      // all ones so the first sof lands on id 0
      frame_id_q         <= '1;
      err_sof_midframe_o <= 1'b0;
    end else begin
      err_sof_midframe_o <= pix_fire && sof_i && (state_q == FR_ACTIVE) &&
                            ((x_q != '0) || (y_q != '0));
      if (pix_take) begin
        frame_id_q <= cur_frame_id;
        if (last_x) begin
          x_q <= '0;
          if (last_y) begin
            y_q     <= '0;
            state_q <= FR_WAIT_SOF;
          end else begin
            y_q     <= cur_y + 1'b1;
            state_q <= FR_ACTIVE;
          end
        end else begin
          x_q     <= cur_x + 1'b1;
          y_q     <= cur_y;
          state_q <= FR_ACTIVE;
        end
      end
    end
  end

  // ------------------------------------------------------------------
  // output stage valid
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst_i) begin
      nb_valid_o <= 1'b0;
    end else if (pix_take) begin
      nb_valid_o <= 1'b1;
    end else if (nb_ready_i) begin
      nb_valid_o <= 1'b0;
    end
  end

  // line memory and neighbour payload
  always_ff @(posedge clk) begin
    if (pix_take) begin
      // old entry at this x is the pixel one line up
      up_pix_o          <= line_mem[cur_x];
      line_mem[cur_x]   <= pix_i;
      left_pix_o        <= left_q;
      left_q            <= pix_i;
      cur_pix_o         <= pix_i;
      x_mod_o           <= cur_x[TILE_SHIFT-1:0];
      y_mod_o           <= cur_y[TILE_SHIFT-1:0];
      tile_x_o          <= cur_x[X_W-1:TILE_SHIFT];
      tile_y_o          <= cur_y[Y_W-1:TILE_SHIFT];
      frame_id_o        <= cur_frame_id;
    end
  end

endmodule

// ==== rtl/tile_feat_pkg.sv ====
// shared frame geometry, field widths and framing state, imported by every tile feature module
package tile_feat_pkg;

  // ------------------------------------------------------------------
  // pixel and frame geometry
  // ------------------------------------------------------------------
  localparam int unsigned PIX_W    = 8;
  localparam int unsigned ACTIVE_W = 16;
  localparam int unsigned ACTIVE_H = 8;

  // tiles are TILE_DIM x TILE_DIM pixels
  localparam int unsigned TILE_SHIFT = 2;
  localparam int unsigned TILE_DIM   = 1 << TILE_SHIFT;
  localparam int unsigned TILES_X    = ACTIVE_W / TILE_DIM;
  localparam int unsigned TILES_Y    = ACTIVE_H / TILE_DIM;

  // coordinate widths
  localparam int unsigned X_W  = 4;
  localparam int unsigned Y_W  = 3;
  localparam int unsigned TX_W = X_W - TILE_SHIFT;
  localparam int unsigned TY_W = Y_W - TILE_SHIFT;

  // ------------------------------------------------------------------
  // statistic widths
  // ------------------------------------------------------------------
  // 16 pixels of 255 max -> 4080
  localparam int unsigned SUM_W = 12;
  // up to 24 in-tile gradient terms of 255 -> 6120
  localparam int unsigned EDGE_W     = 13;
  localparam int unsigned FRAME_ID_W = 8;

  // record buffer between accumulator and output port
  localparam int unsigned FIFO_DEPTH = 4;

  // packed record, msb first: tile x, tile y, frame id, sum, min, max, edge
  localparam int unsigned REC_W = TX_W + TY_W + FRAME_ID_W + SUM_W + 2 * PIX_W + EDGE_W;

  // ------------------------------------------------------------------
  // framing state of the pixel counter
  // ------------------------------------------------------------------
  typedef enum logic [0:0] {
    FR_WAIT_SOF = 1'b0,  // drop pixels until a start of frame
    FR_ACTIVE   = 1'b1   // counting pixels inside a frame
  } frame_state_t;

endpackage

// ==== rtl/tile_feat_top.sv ====
// tile feature extractor top, chains line buffer, tile accumulator and record FIFO to the output port
module tile_feat_top (
  input  logic                                 clk,
  input  logic                                 rst_i,
  input  logic                                 pix_valid_i,
  output logic                                 pix_ready_o,
  input  logic                                 sof_i,
  input  logic [tile_feat_pkg::PIX_W-1:0]      pix_i,
  output logic                                 out_valid_o,
  input  logic                                 out_ready_i,
  output logic [tile_feat_pkg::TX_W-1:0]       tile_x_o,
  output logic [tile_feat_pkg::TY_W-1:0]       tile_y_o,
  output logic [tile_feat_pkg::FRAME_ID_W-1:0] frame_id_o,
  output logic [tile_feat_pkg::SUM_W-1:0]      sum_o,
  output logic [tile_feat_pkg::PIX_W-1:0]      min_o,
  output logic [tile_feat_pkg::PIX_W-1:0]      max_o,
  output logic [tile_feat_pkg::PIX_W-1:0]      mean_o,
  output logic [tile_feat_pkg::EDGE_W-1:0]     edge_o,
  output logic                                 err_sof_midframe_o
);
  import tile_feat_pkg::*;

  // neighbour stream
  logic                  nb_valid;
  logic                  nb_ready;
  logic [PIX_W-1:0]      cur_pix;
  logic [PIX_W-1:0]      left_pix;
  logic [PIX_W-1:0]      up_pix;
  logic [TILE_SHIFT-1:0] x_mod;
  logic [TILE_SHIFT-1:0] y_mod;
  logic [TX_W-1:0]       tile_x;
  logic [TY_W-1:0]       tile_y;
  logic [FRAME_ID_W-1:0] frame_id;

  // record stream
  logic                  rec_valid;
  logic                  rec_ready;
  logic [REC_W-1:0]      rec_data;
  logic [REC_W-1:0]      out_data;

  pix_linebuf u_linebuf (
    .clk                (clk),
    .rst_i              (rst_i),
    .pix_valid_i        (pix_valid_i),
    .pix_ready_o        (pix_ready_o),
    .sof_i              (sof_i),
    .pix_i              (pix_i),
    .nb_valid_o         (nb_valid),
    .nb_ready_i         (nb_ready),
    .cur_pix_o          (cur_pix),
    .left_pix_o         (left_pix),
    .up_pix_o           (up_pix),
    .x_mod_o            (x_mod),
    .y_mod_o            (y_mod),
    .tile_x_o           (tile_x),
    .tile_y_o           (tile_y),
    .frame_id_o         (frame_id),
    .err_sof_midframe_o (err_sof_midframe_o)
  );

  tile_stats_accum u_accum (
    .clk         (clk),
    .rst_i       (rst_i),
    .nb_valid_i  (nb_valid),
    .nb_ready_o  (nb_ready),
    .cur_pix_i   (cur_pix),
    .left_pix_i  (left_pix),
    .up_pix_i    (up_pix),
    .x_mod_i     (x_mod),
    .y_mod_i     (y_mod),
    .tile_x_i    (tile_x),
    .tile_y_i    (tile_y),
    .frame_id_i  (frame_id),
    .rec_valid_o (rec_valid),
    .rec_ready_i (rec_ready),
    .rec_data_o  (rec_data)
  );

  tile_out_fifo u_out_fifo (
    .clk          (clk),
    .rst_i        (rst_i),
    .push_valid_i (rec_valid),
    .push_ready_o (rec_ready),
    .push_data_i  (rec_data),
    .pop_valid_o  (out_valid_o),
    .pop_ready_i  (out_ready_i),
    .pop_data_o   (out_data)
  );

  // ------------------------------------------------------------------
  // record unpack, same field order as the accumulator packs it
  // ------------------------------------------------------------------
  assign {tile_x_o, tile_y_o, frame_id_o, sum_o, min_o, max_o, edge_o} = out_data;

  // 16 pixels per tile, mean is sum over 2^(2*TILE_SHIFT)
  assign mean_o = PIX_W'(sum_o >> (2 * TILE_SHIFT));

endmodule

// ==== rtl/tile_out_fifo.sv ====
// small record FIFO with ready/valid on the push and pop sides, sits before the output port
module tile_out_fifo (
  input  logic                            clk,
  input  logic                            rst_i,
  input  logic                            push_valid_i,
  output logic                            push_ready_o,
  input  logic [tile_feat_pkg::REC_W-1:0] push_data_i,
  output logic                            pop_valid_o,
  input  logic                            pop_ready_i,
  output logic [tile_feat_pkg::REC_W-1:0] pop_data_o
);
  import tile_feat_pkg::*;

  logic [REC_W-1:0]                  mem [FIFO_DEPTH];
  // depth is a power of two, pointers wrap on their own
  logic [$clog2(FIFO_DEPTH)-1:0]     wr_ptr;
  logic [$clog2(FIFO_DEPTH)-1:0]     rd_ptr;
  logic [$clog2(FIFO_DEPTH+1)-1:0]   count;

  logic                              push_fire;
  logic                              pop_fire;

  // ------------------------------------------------------------------
  // flags and handshakes
  // ------------------------------------------------------------------
  assign push_ready_o = (count != ($clog2(FIFO_DEPTH+1))'(FIFO_DEPTH));
  assign pop_valid_o  = (count != '0);
  assign pop_data_o   = mem[rd_ptr];

  assign push_fire = push_valid_i && push_ready_o;
  assign pop_fire  = pop_valid_o && pop_ready_i;

  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_fire) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_fire) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves count alone
      if (push_fire && !pop_fire) begin
        count <= count + 1'b1;
      end else if (pop_fire && !push_fire) begin
        count <= count - 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (push_fire) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

endmodule

// ==== rtl/tile_stats_accum.sv ====
// per tile-column accumulation of luma sum, min, max and edge energy, one record per finished tile
module tile_stats_accum (
  input  logic                                 clk,
  input  logic                                 rst_i,
  input  logic                                 nb_valid_i,
  output logic                                 nb_ready_o,
  input  logic [tile_feat_pkg::PIX_W-1:0]      cur_pix_i,
  input  logic [tile_feat_pkg::PIX_W-1:0]      left_pix_i,
  input  logic [tile_feat_pkg::PIX_W-1:0]      up_pix_i,
  input  logic [tile_feat_pkg::TILE_SHIFT-1:0] x_mod_i,
  input  logic [tile_feat_pkg::TILE_SHIFT-1:0] y_mod_i,
  input  logic [tile_feat_pkg::TX_W-1:0]       tile_x_i,
  input  logic [tile_feat_pkg::TY_W-1:0]       tile_y_i,
  input  logic [tile_feat_pkg::FRAME_ID_W-1:0] frame_id_i,
  output logic                                 rec_valid_o,
  input  logic                                 rec_ready_i,
  output logic [tile_feat_pkg::REC_W-1:0]      rec_data_o
);
  import tile_feat_pkg::*;

  // ------------------------------------------------------------------
  // accumulator sets, one per tile column
  // ------------------------------------------------------------------
  // a raster row crosses every tile column, so each keeps its own partials
  logic [SUM_W-1:0]  sum_acc  [TILES_X];
  logic [PIX_W-1:0]  min_acc  [TILES_X];
  logic [PIX_W-1:0]  max_acc  [TILES_X];
  logic [EDGE_W-1:0] edge_acc [TILES_X];

  logic              nb_fire;
  logic              tile_first;
  logic              tile_last;

  logic [PIX_W-1:0]  diff_left;
  logic [PIX_W-1:0]  diff_up;
  logic [PIX_W:0]    edge_inc;

  logic [SUM_W-1:0]  sum_nxt;
  logic [PIX_W-1:0]  min_nxt;
  logic [PIX_W-1:0]  max_nxt;
  logic [EDGE_W-1:0] edge_nxt;

  function automatic logic [PIX_W-1:0] abs_diff(
    input logic [PIX_W-1:0] a,
    input logic [PIX_W-1:0] b
  );
    return (a > b) ? (a - b) : (b - a);
  endfunction

  // held off only while a finished record is stuck
  assign nb_ready_o = !rec_valid_o || rec_ready_i;
  assign nb_fire    = nb_valid_i && nb_ready_o;

  assign tile_first = (x_mod_i == '0) && (y_mod_i == '0);
  assign tile_last  = (x_mod_i == '1) && (y_mod_i == '1);

  // ------------------------------------------------------------------
  // gradient of the current pixel, in-tile neighbours only
  // ------------------------------------------------------------------
  assign diff_left = abs_diff(cur_pix_i, left_pix_i);
  assign diff_up   = abs_diff(cur_pix_i, up_pix_i);

  always_comb begin
    edge_inc = '0;
    // left neighbour lies in the previous tile at x_mod 0
    if (x_mod_i != '0) begin
      edge_inc = edge_inc + {1'b0, diff_left};
    end
    // upper neighbour lies in the tile row above at y_mod 0
    if (y_mod_i != '0) begin
      edge_inc = edge_inc + {1'b0, diff_up};
    end
  end

  // ------------------------------------------------------------------
  // next accumulator values
  // ------------------------------------------------------------------
  always_comb begin
    if (tile_first) begin
      // fresh tile, drop whatever the column held before
      sum_nxt  = SUM_W'(cur_pix_i);
      min_nxt  = cur_pix_i;
      max_nxt  = cur_pix_i;
      edge_nxt = EDGE_W'(edge_inc);
    end else begin
      sum_nxt  = sum_acc[tile_x_i] + SUM_W'(cur_pix_i);
      min_nxt  = (cur_pix_i < min_acc[tile_x_i]) ? cur_pix_i : min_acc[tile_x_i];
      max_nxt  = (cur_pix_i > max_acc[tile_x_i]) ? cur_pix_i : max_acc[tile_x_i];
      edge_nxt = edge_acc[tile_x_i] + EDGE_W'(edge_inc);
    end
  end

  always_ff @(posedge clk) begin
    if (nb_fire) begin
      sum_acc[tile_x_i]  <= sum_nxt;
      min_acc[tile_x_i]  <= min_nxt;
      max_acc[tile_x_i]  <= max_nxt;
      edge_acc[tile_x_i] <= edge_nxt;
    end
  end

  // ------------------------------------------------------------------
  // record register
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst_i) begin
      rec_valid_o <= 1'b0;
    end else if (nb_fire && tile_last) begin
      rec_valid_o <= 1'b1;
    end else if (rec_ready_i) begin
      rec_valid_o <= 1'b0;
    end
  end

  // pack on the last pixel, using its tile coordinates and frame id
  always_ff @(posedge clk) begin
    if (nb_fire && tile_last) begin
      rec_data_o <= {tile_x_i, tile_y_i, frame_id_i, sum_nxt, min_nxt, max_nxt, edge_nxt};
    end
  end

endmodule

// ==== tile_feat_top.f ====
+incdir+dv
rtl/tile_feat_pkg.sv
rtl/pix_linebuf.sv
rtl/tile_stats_accum.sv
rtl/tile_out_fifo.sv
rtl/tile_feat_top.sv
dv/tile_feat_tb.sv
